/* common/aqlad_pkg.sv */
package aqlad_pkg;

	////////////////////////////// wishbone
	typedef logic [2:0]  wb_adr_t;	// word address
	typedef logic [31:0] wb_dat_t;

	// host side of a classic cycle
	typedef struct packed {
		logic    cyc;
		logic    stb;
		logic    we;
		wb_adr_t adr;
		wb_dat_t dat;
	} wb_req_t;

	////////////////////////////// register map
	localparam wb_adr_t REG_CTRL     = 3'd0;	// bit0 sw_en, bit1 cal start
	localparam wb_adr_t REG_SW_DELAY = 3'd1;
	localparam wb_adr_t REG_SW_LEN   = 3'd2;
	localparam wb_adr_t REG_SW_CYCLE = 3'd3;
	localparam wb_adr_t REG_ADC1_SPI = 3'd4;
	localparam wb_adr_t REG_ADC2_SPI = 3'd5;
	localparam wb_adr_t REG_STATUS   = 3'd6;

	// status word, trigger count sits in 31:16
	localparam int ST_ADC1_BUSY = 2;
	localparam int ST_ADC2_BUSY = 3;
	localparam int ST_CAL_BUSY  = 4;
	localparam int ST_SW_DONE   = 5;

	////////////////////////////// widths
	localparam int SW_TIME_W   = 20;	// switch delay / length
	localparam int SW_CYC_W    = 14;	// number of pulses
	localparam int SPI_FRAME_W = 24;

	typedef logic [SPI_FRAME_W-1:0] spi_frame_t;

	// switch settings, 55 bits
	typedef struct packed {
		logic                 en;
		logic [SW_TIME_W-1:0] delay;
		logic [SW_TIME_W-1:0] len;
		logic [SW_CYC_W-1:0]  cycle;
	} sw_cfg_t;

	// spi pins of one adc
	typedef struct packed {
		logic scsn;
		logic sclk;
		logic sdi;
	} adc_spi_t;

	////////////////////////////// defaults for the top level
	localparam int SCLK_DIV_DEF  = 2;	// clk_i cycles per sclk half period
	localparam int CAL_SETUP_DEF = 8;	// caldly high to cal high
	localparam int CAL_PULSE_DEF = 16;	// cal width

endpackage

/* adc_cfg/adc_spi_cfg.sv */
`timescale 1ns/1ps

module adc_spi_cfg #(
	parameter int SCLK_DIV = 2	// clk_i cycles per sclk half period
) (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  start_i,
	input  aqlad_pkg::spi_frame_t frame_i,
	output logic                  busy_o,
	output aqlad_pkg::adc_spi_t   spi_o
);
	import aqlad_pkg::*;

	localparam int DIV_W = $clog2(SCLK_DIV) + 1;

	logic             active;	// frame in progress, scsn low
	logic             sclk_q;
	logic [DIV_W-1:0] div_cnt;	// half period counter
	logic [4:0]       bit_cnt;	// bits sent, 24 means tail cycle
	spi_frame_t       shift_q;

	////////////////////////////// control
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			active  <= 1'b0;
			sclk_q  <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (!active) begin
			if (start_i) begin
				active  <= 1'b1;
				sclk_q  <= 1'b0;
				div_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (bit_cnt == 5'(SPI_FRAME_W)) begin
			active <= 1'b0;	// one cycle after the last sclk fall
		end else if (div_cnt == DIV_W'(SCLK_DIV - 1)) begin
			div_cnt <= '0;
			sclk_q  <= ~sclk_q;	// rise mid bit, fall at bit end
			if (sclk_q) begin
				bit_cnt <= bit_cnt + 5'd1;
			end
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	////////////////////////////// shift, msb first
	always_ff @(posedge clk_i) begin
		if (!active && start_i) begin
			shift_q <= frame_i;
		end else if (active && sclk_q && div_cnt == DIV_W'(SCLK_DIV - 1)) begin
			shift_q <= {shift_q[SPI_FRAME_W-2:0], 1'b0};	// next bit while sclk low
		end
	end

	assign busy_o     = active;
	assign spi_o.scsn = ~active;
	assign spi_o.sclk = sclk_q;
	assign spi_o.sdi  = active & shift_q[SPI_FRAME_W-1];

endmodule

/* adc_cfg/adc_calib.sv */
`timescale 1ns/1ps

module adc_calib #(
	parameter int CAL_SETUP = 8,	// caldly high to cal high
	parameter int CAL_PULSE = 16	// cal width
) (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic start_i,
	input  logic calrun1_i,
	input  logic calrun2_i,
	output logic busy_o,
	output logic cal_o,
	output logic caldly_o
);
	localparam int CNT_MAX = (CAL_SETUP > CAL_PULSE) ? CAL_SETUP : CAL_PULSE;
	localparam int CNT_W   = $clog2(CNT_MAX + 1);

	typedef enum logic [1:0] {
		C_IDLE,
		C_SETUP,
		C_PULSE,
		C_WAIT	// until both calrun low
	} cal_state_t;

	cal_state_t       state;
	logic [CNT_W-1:0] cnt;

	////////////////////////////// sequencer
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state <= C_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				C_IDLE: begin
					if (start_i) begin	// ignored in any other state
						state <= C_SETUP;
						cnt   <= '0;
					end
				end
				C_SETUP: begin
					if (cnt == CNT_W'(CAL_SETUP - 1)) begin
						state <= C_PULSE;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				C_PULSE: begin
					if (cnt == CNT_W'(CAL_PULSE - 1)) begin
						state <= C_WAIT;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				C_WAIT: begin
					if (!calrun1_i && !calrun2_i) state <= C_IDLE;	// open ended wait
				end
				default: state <= C_IDLE;
			endcase
		end
	end

	assign caldly_o = (state != C_IDLE);
	assign cal_o    = (state == C_PULSE);
	assign busy_o   = caldly_o;

endmodule

/* logic/wb_regs.sv */
`timescale 1ns/1ps

module wb_regs (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  aqlad_pkg::wb_req_t    wb_i,
	output aqlad_pkg::wb_dat_t    wb_dat_o,
	output logic                  wb_ack_o,
	// spi writers
	output logic                  spi1_start_o,
	output logic                  spi2_start_o,
	output aqlad_pkg::spi_frame_t spi_frame_o,
	input  logic                  spi1_busy_i,
	input  logic                  spi2_busy_i,
	// calibration
	output logic                  cal_start_o,
	input  logic                  cal_busy_i,
	// switch
	output aqlad_pkg::sw_cfg_t    sw_cfg_o,
	input  logic [15:0]           trig_cnt_i,
	input  logic                  sw_done_i
);
	import aqlad_pkg::*;

	logic       req;	// new cycle seen
	logic       stall;	// target spi writer busy
	logic       accept;
	logic       wr;
	logic       hit_spi1, hit_spi2;
	wb_dat_t    rd_dat;
	spi_frame_t adc1_frame, adc2_frame;	// last frames, for readback

	////////////////////////////// decode
	// ack is a one cycle pulse, so skip the cycle it is already high
	assign req      = wb_i.cyc & wb_i.stb & ~wb_ack_o;
	assign hit_spi1 = (wb_i.adr == REG_ADC1_SPI);
	assign hit_spi2 = (wb_i.adr == REG_ADC2_SPI);
	assign stall    = wb_i.we & ((hit_spi1 & spi1_busy_i) | (hit_spi2 & spi2_busy_i));
	assign accept   = req & ~stall;
	assign wr       = accept & wb_i.we;

	// read mux
	always_comb begin
		rd_dat = '0;
		case (wb_i.adr)
			REG_CTRL: begin
				rd_dat[0] = sw_cfg_o.en;	// bit1 reads 0
			end
			REG_SW_DELAY: begin
				rd_dat[SW_TIME_W-1:0] = sw_cfg_o.delay;
			end
			REG_SW_LEN: begin
				rd_dat[SW_TIME_W-1:0] = sw_cfg_o.len;
			end
			REG_SW_CYCLE: begin
				rd_dat[SW_CYC_W-1:0] = sw_cfg_o.cycle;
			end
			REG_ADC1_SPI: begin
				rd_dat[SPI_FRAME_W-1:0] = adc1_frame;
			end
			REG_ADC2_SPI: begin
				rd_dat[SPI_FRAME_W-1:0] = adc2_frame;
			end
			REG_STATUS: begin
				rd_dat[ST_ADC1_BUSY] = spi1_busy_i;
				rd_dat[ST_ADC2_BUSY] = spi2_busy_i;
				rd_dat[ST_CAL_BUSY]  = cal_busy_i;
				rd_dat[ST_SW_DONE]   = sw_done_i;
				rd_dat[31:16]        = trig_cnt_i;
			end
			default: ;	// unmapped reads as 0
		endcase
	end

	////////////////////////////// registers
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wb_ack_o     <= 1'b0;
			wb_dat_o     <= '0;
			spi1_start_o <= 1'b0;
			spi2_start_o <= 1'b0;
			spi_frame_o  <= '0;
			cal_start_o  <= 1'b0;
			sw_cfg_o     <= '0;
			adc1_frame   <= '0;
			adc2_frame   <= '0;
		end else begin
			wb_ack_o     <= accept;
			// start pulses go out with the ack
			spi1_start_o <= wr & hit_spi1;
			spi2_start_o <= wr & hit_spi2;
			cal_start_o  <= wr & (wb_i.adr == REG_CTRL) & wb_i.dat[1];	// adc_calib drops it if busy

			if (accept && !wb_i.we) begin
				wb_dat_o <= rd_dat;
			end

			if (wr) begin
				case (wb_i.adr)
					REG_CTRL:     sw_cfg_o.en    <= wb_i.dat[0];
					REG_SW_DELAY: sw_cfg_o.delay <= wb_i.dat[SW_TIME_W-1:0];
					REG_SW_LEN:   sw_cfg_o.len   <= wb_i.dat[SW_TIME_W-1:0];
					REG_SW_CYCLE: sw_cfg_o.cycle <= wb_i.dat[SW_CYC_W-1:0];
					REG_ADC1_SPI: begin
						adc1_frame  <= wb_i.dat[SPI_FRAME_W-1:0];
						spi_frame_o <= wb_i.dat[SPI_FRAME_W-1:0];
					end
					REG_ADC2_SPI: begin
						adc2_frame  <= wb_i.dat[SPI_FRAME_W-1:0];
						spi_frame_o <= wb_i.dat[SPI_FRAME_W-1:0];
					end
					default: ;	// status is read only
				endcase
			end
		end
	end

endmodule

/* logic/trig_switch.sv */
`timescale 1ns/1ps

module trig_switch (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  aqlad_pkg::sw_cfg_t cfg_i,
	input  logic               trigger_i,	// async
	output logic               switch_o,
	output logic [15:0]        trig_cnt_o,	// accepted triggers
	output logic               done_o
);
	import aqlad_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_DELAY,
		S_PULSE
	} state_t;

	state_t               state;
	logic                 trig_s1, trig_s2, trig_s3;	// 2 sync flops + history
	logic                 edge_q;	// registered rising edge
	logic                 accept;
	logic [SW_TIME_W-1:0] cnt;

	////////////////////////////// trigger sync and edge
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			trig_s1 <= 1'b0;
			trig_s2 <= 1'b0;
			trig_s3 <= 1'b0;
			edge_q  <= 1'b0;
		end else begin
			trig_s1 <= trigger_i;
			trig_s2 <= trig_s1;
			trig_s3 <= trig_s2;
			edge_q  <= trig_s2 & ~trig_s3;
		end
	end

	// only taken when idle and not yet done
	assign accept = edge_q & cfg_i.en & ~done_o & (state == S_IDLE);

	////////////////////////////// delay / length / cycle
	always_ff @(posedge clk_i) begin
		if (!rst_n_i || !cfg_i.en) begin	// sw_en low rearms
			state      <= S_IDLE;
			cnt        <= '0;
			trig_cnt_o <= '0;
			done_o     <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (accept) begin
						trig_cnt_o <= trig_cnt_o + 16'd1;
						cnt        <= SW_TIME_W'(1);
						state      <= (cfg_i.delay == '0) ? S_PULSE : S_DELAY;
					end
				end
				S_DELAY: begin
					if (cnt >= cfg_i.delay) begin
						cnt   <= SW_TIME_W'(1);
						state <= S_PULSE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				S_PULSE: begin
					if (cnt >= cfg_i.len) begin	// len 0 still gives one cycle
						state <= S_IDLE;
						// cycle 0 never finishes
						done_o <= (trig_cnt_o == 16'(cfg_i.cycle));
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	assign switch_o = (state == S_PULSE);

endmodule

/* logic/aqlad_ctrl_top.sv */
`timescale 1ns/1ps

module aqlad_ctrl_top #(
	parameter int SCLK_DIV  = aqlad_pkg::SCLK_DIV_DEF,
	parameter int CAL_SETUP = aqlad_pkg::CAL_SETUP_DEF,
	parameter int CAL_PULSE = aqlad_pkg::CAL_PULSE_DEF
) (
	input  logic                clk_i,
	input  logic                rst_n_i,
	// host bus
	input  aqlad_pkg::wb_req_t  wb_i,
	output aqlad_pkg::wb_dat_t  wb_dat_o,
	output logic                wb_ack_o,
	// adc config and calibration
	output aqlad_pkg::adc_spi_t adc1_spi_o,
	output aqlad_pkg::adc_spi_t adc2_spi_o,
	input  logic                adc1_calrun_i,
	input  logic                adc2_calrun_i,
	output logic                adc_cal_o,	// shared by both adcs
	output logic                adc_caldly_o,
	// switch
	input  logic                trigger_i,
	output logic                switch_o,
	output logic [2:0]          led_o
);
	import aqlad_pkg::*;

	logic       spi1_start, spi2_start;
	logic       spi1_busy, spi2_busy;
	spi_frame_t spi_frame;	// one frame bus, only one start at a time
	logic       cal_start, cal_busy;
	sw_cfg_t    sw_cfg;
	logic [15:0] trig_cnt;
	logic       sw_done;

	////////////////////////////// register file
	wb_regs u_regs (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.wb_i         (wb_i),
		.wb_dat_o     (wb_dat_o),
		.wb_ack_o     (wb_ack_o),
		.spi1_start_o (spi1_start),
		.spi2_start_o (spi2_start),
		.spi_frame_o  (spi_frame),
		.spi1_busy_i  (spi1_busy),
		.spi2_busy_i  (spi2_busy),
		.cal_start_o  (cal_start),
		.cal_busy_i   (cal_busy),
		.sw_cfg_o     (sw_cfg),
		.trig_cnt_i   (trig_cnt),
		.sw_done_i    (sw_done)
	);

	////////////////////////////// adc config
	adc_spi_cfg #(.SCLK_DIV(SCLK_DIV)) u_spi1 (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.start_i (spi1_start),
		.frame_i (spi_frame),
		.busy_o  (spi1_busy),
		.spi_o   (adc1_spi_o)
	);

	adc_spi_cfg #(.SCLK_DIV(SCLK_DIV)) u_spi2 (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.start_i (spi2_start),
		.frame_i (spi_frame),
		.busy_o  (spi2_busy),
		.spi_o   (adc2_spi_o)
	);

	adc_calib #(.CAL_SETUP(CAL_SETUP), .CAL_PULSE(CAL_PULSE)) u_calib (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.start_i   (cal_start),
		.calrun1_i (adc1_calrun_i),
		.calrun2_i (adc2_calrun_i),
		.busy_o    (cal_busy),
		.cal_o     (adc_cal_o),
		.caldly_o  (adc_caldly_o)
	);

	////////////////////////////// switch
	trig_switch u_switch (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.cfg_i      (sw_cfg),
		.trigger_i  (trigger_i),
		.switch_o   (switch_o),
		.trig_cnt_o (trig_cnt),
		.done_o     (sw_done)
	);

	// leds follow calrun
	assign led_o[0] = adc1_calrun_i & adc2_calrun_i;	// both running
	assign led_o[1] = adc1_calrun_i;
	assign led_o[2] = adc2_calrun_i;

endmodule

/* test/aqlad_asserts.sv */
`timescale 1ns/1ps

module aqlad_asserts (
	input logic clk_i,
	input logic rst_n_i,
	input logic ack_i,	// wishbone ack, tied low on spi binds
	input logic scsn_i,
	input logic sclk_i,
	input logic start_i,
	input logic busy_i
);
	int unsigned fail_cnt = 0;	// summed at end of run

	// sclk idles low outside a frame
	a_sclk_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i) scsn_i |-> !sclk_i)
	else begin
		fail_cnt++;
		$error("sclk high while scsn high");
	end

	// ack is a single cycle pulse
	a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i) ack_i |=> !ack_i)
	else begin
		fail_cnt++;
		$error("wb_ack_o high for two cycles");
	end

	a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i) start_i |-> !busy_i)
	else begin
		fail_cnt++;
		$error("start while writer busy");
	end

endmodule

////////////////////////////// binds
bind adc_spi_cfg aqlad_asserts u_spi_asserts (
	.clk_i   (clk_i),
	.rst_n_i (rst_n_i),
	.ack_i   (1'b0),
	.scsn_i  (spi_o.scsn),
	.sclk_i  (spi_o.sclk),
	.start_i (start_i),
	.busy_i  (busy_o)
);

bind wb_regs aqlad_asserts u_wb_asserts (
	.clk_i   (clk_i),
	.rst_n_i (rst_n_i),
	.ack_i   (wb_ack_o),
	.scsn_i  (1'b1),
	.sclk_i  (1'b0),
	.start_i (1'b0),
	.busy_i  (1'b0)
);

/* test/tb_aqlad.sv */
`timescale 1ns/1ps

module tb_aqlad;
	import aqlad_pkg::*;

	localparam int SCLK_DIV   = SCLK_DIV_DEF;
	localparam int CAL_SETUP  = CAL_SETUP_DEF;
	localparam int CAL_PULSE  = CAL_PULSE_DEF;
	localparam int CLK_PERIOD = 10;
	localparam int SW_D       = 6;	// switch delay
	localparam int SW_L       = 8;	// long enough to swallow a retrigger
	localparam int FRAME_CYC  = SPI_FRAME_W * 2 * SCLK_DIV + 4;
	localparam int ACK_LIMIT  = FRAME_CYC + 20;	// worst stall is one frame
	localparam int RUN_CYC    = 10 + 40 + (FRAME_CYC + 20) + (2 * FRAME_CYC + 40)
		+ 3 * (SW_D + SW_L + 30) + 40 + (CAL_SETUP + CAL_PULSE + 80);
	localparam int WATCHDOG_CYC = 2 * RUN_CYC + 100;

	logic        clk_i;
	logic        rst_n_i;
	wb_req_t     wb_i;
	wb_dat_t     wb_dat_o;
	logic        wb_ack_o;
	adc_spi_t    adc1_spi_o, adc2_spi_o;
	logic        adc1_calrun_i, adc2_calrun_i;
	logic        adc_cal_o, adc_caldly_o;
	logic        trigger_i, switch_o;
	logic [2:0]  led_o;
	int unsigned tick_cnt = 0;	// clock edges since start
	int unsigned ack_tick;	// edge of the last ack
	int unsigned ack_wait;	// cycles from request to ack
	logic [31:0] rng_state = 32'hba65;

	aqlad_ctrl_top #(
		.SCLK_DIV  (SCLK_DIV),
		.CAL_SETUP (CAL_SETUP),
		.CAL_PULSE (CAL_PULSE)
	) UUT (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.wb_i          (wb_i),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o),
		.adc1_spi_o    (adc1_spi_o),
		.adc2_spi_o    (adc2_spi_o),
		.adc1_calrun_i (adc1_calrun_i),
		.adc2_calrun_i (adc2_calrun_i),
		.adc_cal_o     (adc_cal_o),
		.adc_caldly_o  (adc_caldly_o),
		.trigger_i     (trigger_i),
		.switch_o      (switch_o),
		.led_o         (led_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	always @(posedge clk_i) tick_cnt <= tick_cnt + 1;

	////////////////////////////// helpers
	// one cycle on, 1 ns past the edge: drive and sample point
	task automatic next_cycle();
		@(posedge clk_i);
		#1;
	endtask

	task automatic stop_failed();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic abort_run(input string why);
		$display("Error at %0t ns: %s", $time, why);
		stop_failed();
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string name);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
			stop_failed();
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic draw_frame(output spi_frame_t f);
		rng_state = xorshift32(rng_state);
		f = rng_state[SPI_FRAME_W-1:0];
	endtask

	// protocol assertion failures in all bound checkers
	function automatic int unsigned protocol_fails();
		return UUT.u_regs.u_wb_asserts.fail_cnt + UUT.u_spi1.u_spi_asserts.fail_cnt
			+ UUT.u_spi2.u_spi_asserts.fail_cnt;
	endfunction

	// waits out a stall, holds the request over the next edge, then drops the cycle
	task automatic wait_ack(input int unsigned start);
		do begin
			next_cycle();
			if (tick_cnt - start > ACK_LIMIT) abort_run("no Wishbone ack");
		end while (!wb_ack_o);
		ack_tick = tick_cnt;
		ack_wait = tick_cnt - start;
		next_cycle();	// stb still high here, ack must not repeat
		wb_i.cyc = 1'b0;
		wb_i.stb = 1'b0;
		wb_i.we  = 1'b0;
	endtask

	task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
		wb_i = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		wait_ack(tick_cnt);
	endtask

	task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
		wb_i = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
		wait_ack(tick_cnt);
		dat = wb_dat_o;	// registered, holds after ack
	endtask

	function automatic adc_spi_t spi_pins(input int ch);
		return (ch == 1) ? adc1_spi_o : adc2_spi_o;
	endfunction

	// one frame off the pins, sdi taken on sclk rise
	task automatic spi_receive(input int ch, output spi_frame_t frame, output int unsigned end_tick);
		adc_spi_t    pins;
		int unsigned guard;
		int unsigned last_rise;
		int          nbits;
		logic        prev_sclk;
		string       name;
		name  = (ch == 1) ? "adc1" : "adc2";
		guard = 0;
		pins  = spi_pins(ch);
		while (pins.scsn) begin
			next_cycle();
			pins = spi_pins(ch);
			guard++;
			if (guard > ACK_LIMIT) abort_run({name, " scsn never went low"});
		end
		last_rise = tick_cnt;	// scsn fall
		nbits     = 0;
		prev_sclk = 1'b0;
		frame     = '0;
		while (nbits < SPI_FRAME_W) begin
			next_cycle();
			pins = spi_pins(ch);
			check(pins.scsn, 1'b0, {name, " scsn"});
			if (pins.sclk && !prev_sclk) begin
				// half a bit after scsn, then a full bit apart
				check(tick_cnt - last_rise, (nbits == 0) ? SCLK_DIV : 2 * SCLK_DIV,
					{name, " sclk rise spacing"});
				frame     = {frame[SPI_FRAME_W-2:0], pins.sdi};	// msb first
				last_rise = tick_cnt;
				nbits++;
			end
			prev_sclk = pins.sclk;
		end
		while (!pins.scsn) begin
			next_cycle();
			pins = spi_pins(ch);
		end
		end_tick = tick_cnt;
		check(end_tick - last_rise, SCLK_DIV + 1, {name, " scsn rise after last bit"});
	endtask

	task automatic fire_trigger(output int unsigned edge_tick);
		trigger_i = 1'b1;
		edge_tick = tick_cnt + 1;	// edge that samples it high
		next_cycle();
		next_cycle();
		trigger_i = 1'b0;
	endtask

	task automatic measure_switch_pulse(input int unsigned edge_tick, input bit retrigger);
		int unsigned guard;
		int unsigned high;
		guard = 0;
		while (!switch_o) begin
			next_cycle();
			guard++;
			if (guard > SW_D + 10) abort_run("switch_o did not rise after trigger");
		end
		check(tick_cnt - edge_tick, SW_D + 3, "switch_o delay");
		high = 0;
		while (switch_o) begin
			high++;
			if (retrigger && high == 1) trigger_i = 1'b1;	// lands mid pulse
			if (retrigger && high == 3) trigger_i = 1'b0;
			next_cycle();
			if (high > SW_L + 5) abort_run("switch_o stuck high");
		end
		trigger_i = 1'b0;
		check(high, SW_L, "switch_o high cycles");
	endtask

	task automatic expect_switch_low(input int n);
		repeat (n) begin
			next_cycle();
			check(switch_o, 1'b0, "switch_o");
		end
	endtask

	////////////////////////////// tests
	task automatic reset_defaults();
		wb_dat_t d;
		check(adc1_spi_o, 3'b100, "adc1_spi_o");	// scsn high only
		check(adc2_spi_o, 3'b100, "adc2_spi_o");
		check(adc_cal_o, 1'b0, "adc_cal_o");
		check(adc_caldly_o, 1'b0, "adc_caldly_o");
		check(switch_o, 1'b0, "switch_o");
		check(wb_ack_o, 1'b0, "wb_ack_o");
		check(wb_dat_o, '0, "wb_dat_o");
		check(led_o, 3'b000, "led_o");
		wb_read(REG_STATUS, d);
		check(d, '0, "status");
		// readback masked to field width
		wb_write(REG_SW_DELAY, 32'hffff_ffff);
		wb_read(REG_SW_DELAY, d);
		check(d, 32'h000f_ffff, "sw delay");
		wb_write(REG_SW_LEN, 32'h5a5a_5a5a);
		wb_read(REG_SW_LEN, d);
		check(d, 32'h000a_5a5a, "sw len");
		wb_write(REG_SW_CYCLE, 32'hffff_ffff);
		wb_read(REG_SW_CYCLE, d);
		check(d, 32'h0000_3fff, "sw cycle");
	endtask

	task automatic spi_single_frame();
		spi_frame_t  tx, rx;
		int unsigned end_tick;
		bit          rx_done;
		wb_dat_t     d;
		draw_frame(tx);
		rx_done = 1'b0;
		fork
			begin
				spi_receive(1, rx, end_tick);
				rx_done = 1'b1;
			end
			wb_write(REG_ADC1_SPI, {8'hff, tx});	// top byte dropped
			while (!rx_done) begin
				next_cycle();
				check(adc2_spi_o, 3'b100, "adc2_spi_o");	// other adc idle
			end
		join
		check(rx, tx, "adc1 frame");
		wb_read(REG_ADC1_SPI, d);
		check(d, {8'h00, tx}, "adc1 frame readback");
	endtask

	task automatic spi_back_pressure();
		spi_frame_t  fa, fb, fc, ra, rb, rc;
		int unsigned end_a, end_b, end_c, ack_b, wait_c;
		wb_dat_t     d;
		draw_frame(fa);
		draw_frame(fb);
		draw_frame(fc);
		fork
			begin
				spi_receive(1, ra, end_a);
				spi_receive(1, rb, end_b);
			end
			spi_receive(2, rc, end_c);
			begin
				wb_write(REG_ADC1_SPI, fa);
				wb_write(REG_ADC2_SPI, fc);	// adc2 free, no stall
				wait_c = ack_wait;
				wb_read(REG_STATUS, d);	// both writers sending
				check(d, (32'd1 << ST_ADC1_BUSY) | (32'd1 << ST_ADC2_BUSY),
					"status while sending");
				wb_write(REG_ADC1_SPI, fb);	// held off while adc1 sends
				ack_b = ack_tick;
			end
		join
		check(wait_c, 1, "adc2 write ack latency");
		check(ack_b, end_a + 1, "stalled adc1 ack cycle");
		check(ra, fa, "adc1 first frame");
		check(rb, fb, "adc1 second frame");
		check(rc, fc, "adc2 frame");
		wb_read(REG_ADC2_SPI, d);
		check(d, {8'h00, fc}, "adc2 frame readback");
	endtask

	task automatic switch_sequence();
		int unsigned edge_tick;
		wb_dat_t     d;
		wb_write(REG_SW_DELAY, SW_D);
		wb_write(REG_SW_LEN, SW_L);
		wb_write(REG_SW_CYCLE, 2);
		wb_write(REG_CTRL, 32'h1);	// sw_en
		fire_trigger(edge_tick);
		measure_switch_pulse(edge_tick, 1'b1);
		expect_switch_low(SW_D + SW_L + 10);	// retrigger gave nothing
		wb_read(REG_STATUS, d);
		check(d, 32'd1 << 16, "status after one pulse");
		fire_trigger(edge_tick);
		measure_switch_pulse(edge_tick, 1'b0);
		// cycle count reached, third trigger dropped
		fire_trigger(edge_tick);
		expect_switch_low(SW_D + SW_L + 10);
		wb_read(REG_STATUS, d);
		check(d, (32'd2 << 16) | (32'd1 << ST_SW_DONE), "status after cycle done");
	endtask

	task automatic calibration_cycle();
		int unsigned dly_tick;
		int unsigned guard;
		int unsigned high;
		wb_dat_t     d;
		adc1_calrun_i = 1'b1;	// adcs report cal running
		adc2_calrun_i = 1'b1;
		next_cycle();
		check(led_o, 3'b111, "led_o");
		wb_write(REG_CTRL, 32'h2);	// cal start, sw_en off
		check(adc_caldly_o, 1'b1, "adc_caldly_o");
		dly_tick = ack_tick + 1;
		guard    = 0;
		while (!adc_cal_o) begin
			next_cycle();
			guard++;
			if (guard > CAL_SETUP + 5) abort_run("adc_cal_o never rose");
		end
		check(tick_cnt - dly_tick, CAL_SETUP, "adc_cal_o setup delay");
		high = 0;
		while (adc_cal_o) begin
			high++;
			check(adc_caldly_o, 1'b1, "adc_caldly_o");
			next_cycle();
			if (high > CAL_PULSE + 5) abort_run("adc_cal_o stuck high");
		end
		check(high, CAL_PULSE, "adc_cal_o pulse width");
		wb_read(REG_STATUS, d);
		check(d, 32'd1 << ST_CAL_BUSY, "status during cal");
		repeat (20) begin
			next_cycle();
			check(adc_caldly_o, 1'b1, "adc_caldly_o");	// still waiting on calrun
		end
		adc1_calrun_i = 1'b0;
		next_cycle();
		check(led_o, 3'b100, "led_o");
		repeat (10) begin
			next_cycle();
			check(adc_caldly_o, 1'b1, "adc_caldly_o");	// one adc still busy
		end
		adc2_calrun_i = 1'b0;
		next_cycle();
		check(adc_caldly_o, 1'b0, "adc_caldly_o");
		check(led_o, 3'b000, "led_o");
		wb_read(REG_STATUS, d);
		check(d, '0, "status after cal");
	endtask

	////////////////////////////// watchdog
	initial begin
		#(WATCHDOG_CYC * CLK_PERIOD);
		abort_run("watchdog expired before the tests finished");
	end

	// bound checkers fire on the rising edge, looked at half a cycle later
	always @(negedge clk_i) begin
		if (protocol_fails() != 0) abort_run("a protocol assertion failed");
	end

	////////////////////////////// main
	initial begin
		int unsigned fails;
		wb_i          = '0;
		rst_n_i       = 1'b0;
		adc1_calrun_i = 1'b0;
		adc2_calrun_i = 1'b0;
		trigger_i     = 1'b0;
		repeat (3) @(posedge clk_i);
		#1;
		rst_n_i = 1'b1;
		reset_defaults();
		spi_single_frame();
		spi_back_pressure();
		switch_sequence();
		calibration_cycle();
		fails = protocol_fails();
		if (fails == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("%0d protocol assertions failed", fails);
			stop_failed();
		end
	end

endmodule

/* flist.f */
common/aqlad_pkg.sv
adc_cfg/adc_spi_cfg.sv
adc_cfg/adc_calib.sv
logic/wb_regs.sv
logic/trig_switch.sv
logic/aqlad_ctrl_top.sv
test/aqlad_asserts.sv
test/tb_aqlad.sv
